//--- design/cart_bank_regs.sv
// MBC bank registers
// cpu writes to 0000-7FFF land here: RAM enable, ROM bank,
// RAM bank and the MBC1 banking mode

`timescale 1ns/10ps

module cart_bank_regs #(
	parameter int CRAM_BANKS = 4
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   ce_cpu,
	input  cart_pkg::cpu_addr_t    cart_addr,
	input  logic                   cart_wr,
	input  cart_pkg::cpu_data_t    cart_di,
	input  cart_pkg::cart_info_t   cart_info,
	output cart_pkg::bank_regs_t   bank_regs
);

	// highest bank the on-chip RAM holds
	localparam cart_pkg::ram_bank_t BANK_LIMIT = cart_pkg::ram_bank_t'(CRAM_BANKS - 1);

	logic is_mbc1;
	logic is_mbc5;

	assign is_mbc1 = (cart_info.kind == cart_pkg::MAP_MBC1);
	assign is_mbc5 = (cart_info.kind == cart_pkg::MAP_MBC5);

	// ------------------------------
	// register writes
	// ------------------------------

	// a fresh download starts from a clean mapper
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			bank_regs.rom_bank   <= 7'd1;
			bank_regs.ram_bank   <= '0;
			bank_regs.mbc1_mode  <= 1'b0;
			bank_regs.ram_enable <= 1'b0;
		end else if (ce_cpu && cart_wr) begin
			case (cart_addr[15:13])
				// 0000-1FFF, only the key opens the RAM
				3'b000: bank_regs.ram_enable <= (cart_di[3:0] == cart_pkg::RAM_ENABLE_KEY);
				// 2000-3FFF
				3'b001: begin
					// bank 0 aliases to 1 except on MBC5
					if (!is_mbc5 && cart_di[4:0] == 5'd0)
						bank_regs.rom_bank <= 7'd1;
					else
						bank_regs.rom_bank <= cart_di[6:0];
				end
				// 4000-5FFF, trimmed to the banks that exist
				3'b010: bank_regs.ram_bank <= cart_di[1:0] & BANK_LIMIT;
				// 6000-7FFF
				3'b011: begin
					if (is_mbc1)
						bank_regs.mbc1_mode <= cart_di[0];
				end
				default: ;
			endcase
		end
	end

endmodule

//--- design/cart_bus_arbiter.sv
// cartridge bus arbiter
// sequences download writes into the ROM store, drives the store
// port from the download or the cpu, and picks the cpu read byte

`timescale 1ns/10ps

module cart_bus_arbiter (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ce_cpu,
	input  logic                     dl_active,
	input  logic                     dl_wr,
	input  cart_pkg::dl_addr_t       dl_addr,
	input  cart_pkg::rom_word_t      dl_data,
	input  cart_pkg::cpu_addr_t      cart_addr,
	input  logic                     cart_rd,
	input  cart_pkg::rom_word_addr_t cpu_rom_addr,
	input  cart_pkg::cpu_data_t      cram_do,
	input  logic                     cram_sel,
	input  cart_pkg::rom_word_t      rom_q,
	output logic                     dl_wait,
	output cart_pkg::rom_word_addr_t rom_addr,
	output cart_pkg::rom_word_t      rom_din,
	output logic                     rom_we,
	output logic                     rom_rd,
	output logic [1:0]               rom_ds,
	output cart_pkg::cpu_data_t      cart_do
);

	logic                     dn_write;
	logic                     cart_ready;
	cart_pkg::rom_word_addr_t dl_word_addr;
	cart_pkg::rom_word_t      dl_word;

	// ------------------------------
	// download write sequence
	// ------------------------------

	// wait rises after dl_wr, arms on one ce_cpu, writes on the next
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait    <= 1'b0;
			dn_write   <= 1'b0;
			cart_ready <= 1'b0;
		end else begin
			if (dl_wr)
				dl_wait <= 1'b1;
			if (ce_cpu) begin
				dn_write <= dl_wait;
				if (dn_write) begin
					dl_wait    <= 1'b0;
					dn_write   <= 1'b0;
					cart_ready <= 1'b1;
				end
			end
		end
	end

	// hold the word so the host may move on once dl_wr is seen
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			dl_word_addr <= dl_addr[24:1];
			dl_word      <= dl_data;
		end
	end

	assign rom_we = dl_active & dn_write & ce_cpu;

	// ------------------------------
	// store port
	// ------------------------------
	assign rom_addr = dl_active ? dl_word_addr : cpu_rom_addr;
	assign rom_din  = dl_active ? dl_word : 16'h0000;
	// whole words on download, one byte lane for the cpu
	assign rom_ds   = dl_active ? 2'b11 : {cart_addr[0], ~cart_addr[0]};
	// cartridge RAM reads keep the store idle
	assign rom_rd   = ~dl_active & cart_rd & ~cram_sel;

	// nothing valid until the first word has landed
	always_comb begin
		if (!cart_ready)
			cart_do = 8'h00;
		else if (cram_sel)
			cart_do = cram_do;
		else if (cart_addr[0])
			cart_do = rom_q[15:8];
		else
			cart_do = rom_q[7:0];
	end

endmodule

//--- design/cart_header_capture.sv
// cartridge header capture
// snoops download writes for the type and size bytes and
// decodes them into the mapper kind and the bank masks

`timescale 1ns/10ps

module cart_header_capture (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  cart_pkg::dl_addr_t     dl_addr,
	input  cart_pkg::rom_word_t    dl_data,
	output cart_pkg::cart_info_t   cart_info
);

	cart_pkg::cpu_data_t mbc_type;
	cart_pkg::cpu_data_t rom_size;
	cart_pkg::cpu_data_t ram_size;

	// header bytes arrive as words, byte order little endian
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mbc_type <= '0;
			rom_size <= '0;
			ram_size <= '0;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == cart_pkg::HDR_MBC_ADDR)
				mbc_type <= dl_data[15:8];
			if (dl_addr == cart_pkg::HDR_SIZE_ADDR)
				{ram_size, rom_size} <= dl_data;
		end
	end

	// ------------------------------
	// decode
	// ------------------------------
	always_comb begin
		case (mbc_type) inside
			[8'd1:8'd3]:   cart_info.kind = cart_pkg::MAP_MBC1;
			[8'd5:8'd6]:   cart_info.kind = cart_pkg::MAP_MBC2;
			[8'd15:8'd19]: cart_info.kind = cart_pkg::MAP_MBC3;
			[8'd25:8'd30]: cart_info.kind = cart_pkg::MAP_MBC5;
			default:       cart_info.kind = cart_pkg::MAP_NONE;
		endcase

		// banks minus one, odd sizes mirror through the gaps
		case (rom_size)
			8'h00:   cart_info.rom_mask = 7'h01;
			8'h01:   cart_info.rom_mask = 7'h03;
			8'h02:   cart_info.rom_mask = 7'h07;
			8'h03:   cart_info.rom_mask = 7'h0F;
			8'h04:   cart_info.rom_mask = 7'h1F;
			8'h05:   cart_info.rom_mask = 7'h3F;
			8'h06:   cart_info.rom_mask = 7'h7F;
			8'h52:   cart_info.rom_mask = 7'h47;
			8'h53:   cart_info.rom_mask = 7'h4F;
			default: cart_info.rom_mask = 7'h5F;
		endcase

		// only the 32 KB RAM is banked
		cart_info.ram_mask = (ram_size >= 8'd3) ? 2'b11 : 2'b00;
	end

endmodule

//--- design/cart_pkg.sv
// cartridge MBC shared definitions
// widths, mapper kinds, header and bank register bundles,
// header byte addresses and the RAM enable key

package cart_pkg;

	// ------------------------------
	// bus and store widths
	// ------------------------------

	// cpu side of the cartridge slot
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// external word-wide ROM store
	typedef logic [23:0] rom_word_addr_t;
	typedef logic [15:0] rom_word_t;

	// download byte address, bit 0 picks the byte in a word
	typedef logic [24:0] dl_addr_t;

	// bank numbers
	typedef logic [6:0] rom_bank_t;
	typedef logic [1:0] ram_bank_t;

	// on-chip cartridge RAM, up to 4 banks of 8 KB
	typedef logic [14:0] cram_addr_t;

	// ------------------------------
	// mapper kinds
	// ------------------------------
	typedef enum logic [2:0] {
		MAP_NONE,
		MAP_MBC1,
		MAP_MBC2,
		MAP_MBC3,
		MAP_MBC5
	} mapper_kind_t;

	// decoded cartridge header
	typedef struct packed {
		mapper_kind_t kind;
		rom_bank_t    rom_mask;
		ram_bank_t    ram_mask;
	} cart_info_t;

	// cpu written bank registers
	typedef struct packed {
		rom_bank_t rom_bank;
		ram_bank_t ram_bank;
		logic      mbc1_mode;
		logic      ram_enable;
	} bank_regs_t;

	// ------------------------------
	// header bytes and keys
	// ------------------------------

	// cartridge type byte, sits in the upper half of word 0x146
	localparam dl_addr_t HDR_MBC_ADDR = 25'h000146;
	// ROM size in the low byte, RAM size in the high byte
	localparam dl_addr_t HDR_SIZE_ADDR = 25'h000148;

	// low nibble written to 0000-1FFF that opens the RAM
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

endpackage

//--- design/gb_cart.sv
// game cartridge top
// header capture, bank registers, ROM and RAM mappers and the
// bus arbiter in front of an external word-wide ROM store

`timescale 1ns/10ps

module gb_cart #(
	parameter int CRAM_BANKS = 4
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ce_cpu,
	input  cart_pkg::cpu_addr_t      cart_addr,
	input  logic                     cart_rd,
	input  logic                     cart_wr,
	input  cart_pkg::cpu_data_t      cart_di,
	output cart_pkg::cpu_data_t      cart_do,
	input  logic                     dl_active,
	input  logic                     dl_wr,
	input  cart_pkg::dl_addr_t       dl_addr,
	input  cart_pkg::rom_word_t      dl_data,
	output logic                     dl_wait,
	output cart_pkg::rom_word_addr_t rom_addr,
	output cart_pkg::rom_word_t      rom_din,
	output logic                     rom_we,
	output logic                     rom_rd,
	output logic [1:0]               rom_ds,
	input  cart_pkg::rom_word_t      rom_q
);

	cart_pkg::cart_info_t     cart_info;
	cart_pkg::bank_regs_t     bank_regs;
	cart_pkg::rom_word_addr_t cpu_rom_addr;
	cart_pkg::cpu_data_t      cram_do;
	logic                     cram_sel;

	// ------------------------------
	// header and registers
	// ------------------------------
	cart_header_capture i_header (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_active(dl_active),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.cart_info(cart_info)
	);

	cart_bank_regs #(.CRAM_BANKS(CRAM_BANKS)) i_bank_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_active(dl_active),
		.ce_cpu   (ce_cpu),
		.cart_addr(cart_addr),
		.cart_wr  (cart_wr),
		.cart_di  (cart_di),
		.cart_info(cart_info),
		.bank_regs(bank_regs)
	);

	// ------------------------------
	// mappers
	// ------------------------------
	rom_bank_mapper i_rom_mapper (
		.cart_addr   (cart_addr),
		.cart_info   (cart_info),
		.bank_regs   (bank_regs),
		.cpu_rom_addr(cpu_rom_addr)
	);

	ram_bank_mapper #(.CRAM_BANKS(CRAM_BANKS)) i_ram_mapper (
		.clk_sys  (clk_sys),
		.ce_cpu   (ce_cpu),
		.cart_addr(cart_addr),
		.cart_rd  (cart_rd),
		.cart_wr  (cart_wr),
		.cart_di  (cart_di),
		.cart_info(cart_info),
		.bank_regs(bank_regs),
		.cram_do  (cram_do),
		.cram_sel (cram_sel)
	);

	// store port and read data
	cart_bus_arbiter i_arbiter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ce_cpu      (ce_cpu),
		.dl_active   (dl_active),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.cart_addr   (cart_addr),
		.cart_rd     (cart_rd),
		.cpu_rom_addr(cpu_rom_addr),
		.cram_do     (cram_do),
		.cram_sel    (cram_sel),
		.rom_q       (rom_q),
		.dl_wait     (dl_wait),
		.rom_addr    (rom_addr),
		.rom_din     (rom_din),
		.rom_we      (rom_we),
		.rom_rd      (rom_rd),
		.rom_ds      (rom_ds),
		.cart_do     (cart_do)
	);

endmodule

//--- design/ram_bank_mapper.sv
// cartridge RAM
// banked byte storage behind A000-BFFF with a registered read,
// plus the disabled and MBC2 nibble read masking

`timescale 1ns/10ps

module ram_bank_mapper #(
	parameter int CRAM_BANKS = 4
) (
	input  logic                   clk_sys,
	input  logic                   ce_cpu,
	input  cart_pkg::cpu_addr_t    cart_addr,
	input  logic                   cart_rd,
	input  logic                   cart_wr,
	input  cart_pkg::cpu_data_t    cart_di,
	input  cart_pkg::cart_info_t   cart_info,
	input  cart_pkg::bank_regs_t   bank_regs,
	output cart_pkg::cpu_data_t    cram_do,
	output logic                   cram_sel
);

	localparam int DEPTH = CRAM_BANKS * 8192;

	cart_pkg::cpu_data_t mem [DEPTH];
	cart_pkg::cpu_data_t cram_q;
	cart_pkg::ram_bank_t bank;
	cart_pkg::cram_addr_t cram_addr;
	logic                is_cram;
	logic                mbc2_nibble;

	// ------------------------------
	// bank select
	// ------------------------------
	always_comb begin
		case (cart_info.kind)
			// mode 0 keeps the RAM in bank 0
			cart_pkg::MAP_MBC1:
				bank = bank_regs.mbc1_mode ? (bank_regs.ram_bank & cart_info.ram_mask) : 2'b00;
			cart_pkg::MAP_MBC3,
			cart_pkg::MAP_MBC5:
				bank = bank_regs.ram_bank & cart_info.ram_mask;
			// MBC2 and plain carts have a single bank
			default:
				bank = 2'b00;
		endcase
	end

	assign cram_addr = {bank, cart_addr[12:0]};

	// A000-BFFF
	assign is_cram  = (cart_addr[15:13] == 3'b101);
	assign cram_sel = is_cram & cart_rd;

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (ce_cpu && cart_wr && is_cram)
			mem[cram_addr] <= cart_di;
		// read follows the address one cycle later
		cram_q <= mem[cram_addr];
	end

	// MBC2 has 512 nibbles at A000-A1FF
	assign mbc2_nibble = (cart_info.kind == cart_pkg::MAP_MBC2) &&
		(cart_addr[15:9] == 7'b1010000);

	// closed RAM floats high on a real cart
	always_comb begin
		if (!bank_regs.ram_enable)
			cram_do = 8'hFF;
		else if (mbc2_nibble)
			cram_do = {4'hF, cram_q[3:0]};
		else
			cram_do = cram_q;
	end

endmodule

//--- design/rom_bank_mapper.sv
// ROM bank mapper
// turns a cpu address into a word address in the ROM store,
// using the mapper kind, the ROM mask and the bank registers

`timescale 1ns/10ps

module rom_bank_mapper (
	input  cart_pkg::cpu_addr_t      cart_addr,
	input  cart_pkg::cart_info_t     cart_info,
	input  cart_pkg::bank_regs_t     bank_regs,
	output cart_pkg::rom_word_addr_t cpu_rom_addr
);

	cart_pkg::rom_bank_t bank_sel;
	cart_pkg::rom_bank_t eff_bank;
	logic [8:0]          bank_field;

	// MBC1 mode 0 lends the RAM bank bits to the ROM bank
	always_comb begin
		bank_sel = bank_regs.rom_bank;
		if (cart_info.kind == cart_pkg::MAP_MBC1 && !bank_regs.mbc1_mode)
			bank_sel[6:5] = bank_regs.ram_bank;
	end

	// mask so small ROMs mirror
	assign eff_bank = bank_sel & cart_info.rom_mask;

	// 16 KB bank field above the 8 KB offset
	always_comb begin
		if (cart_info.kind == cart_pkg::MAP_NONE)
			// plain 32 KB cart, linear
			bank_field = {7'd0, cart_addr[14:13]};
		else if (cart_addr[15:14] == 2'b00)
			// fixed bank 0
			bank_field = {8'd0, cart_addr[13]};
		else if (cart_addr[15:14] == 2'b01)
			// switchable window
			bank_field = {1'b0, eff_bank, cart_addr[13]};
		else
			bank_field = '0;
	end

	// word address, byte select comes from cart_addr[0]
	assign cpu_rom_addr = {3'b000, bank_field, cart_addr[12:1]};

endmodule

//--- filelist.f
design/cart_pkg.sv
design/cart_header_capture.sv
design/cart_bank_regs.sv
design/rom_bank_mapper.sv
design/ram_bank_mapper.sv
design/cart_bus_arbiter.sv
design/gb_cart.sv
verification/gb_cart_properties.sv
verification/gb_cart_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the cartridge testbench with Verilator, run it, log in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module gb_cart_tb \
	-f filelist.f -o sim_gb_cart > sim.log 2>&1 \
	&& ./obj_dir/sim_gb_cart >> sim.log 2>&1 \
	|| echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
exit 0

//--- verification/gb_cart_properties.sv
// download and ROM store port checks
// bound onto the cartridge top, reports through failed assertions

`timescale 1ns/10ps

module gb_cart_properties (
	input logic clk_sys,
	input logic reset,
	input logic dl_active,
	input logic dl_wr,
	input logic dl_wait,
	input logic rom_we,
	input logic rom_rd
);

	// ------------------------------
	// download path
	// ------------------------------

	// store writes belong to a download and close a pending wait
	we_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> dl_active && dl_wait)
		else $error("rom_we outside a download or without a pending dl_wait");

	// wait answers the write pulse on the next edge
	wait_after_wr: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |=> dl_wait)
		else $error("dl_wait did not rise one cycle after dl_wr");

	// wait never rises on its own
	wait_rise_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(dl_wait) |-> $past(dl_wr))
		else $error("dl_wait rose without a dl_wr pulse");

	// ------------------------------
	// store port
	// ------------------------------

	// written or read, never both in one cycle
	no_we_rd_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_we && rom_rd))
		else $error("rom_we and rom_rd high together");

endmodule

bind gb_cart gb_cart_properties i_gb_cart_properties (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.dl_active(dl_active),
	.dl_wr    (dl_wr),
	.dl_wait  (dl_wait),
	.rom_we   (rom_we),
	.rom_rd   (rom_rd)
);

//--- verification/gb_cart_tb.sv
// testbench for the cartridge MBC core
// drives downloads and cpu cycles, models the word-wide ROM store
// and checks store addresses and read data against the mapper rules

`timescale 1ns/10ps

module gb_cart_tb;

	localparam int CE_PERIOD   = 8;
	localparam int N_DOWNLOADS = 11;
	localparam int N_WRITES    = 39;
	localparam int N_READS     = 31;
	// worst case clk_sys cycles of the whole run
	localparam int RUN_CYCLES  = 10 + N_DOWNLOADS * 4 * CE_PERIOD +
		N_WRITES * 2 * CE_PERIOD + N_READS * 4;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     ce_cpu = 1'b0;
	logic [2:0]               ce_phase = 3'd0;
	cart_pkg::cpu_addr_t      cart_addr;
	logic                     cart_rd;
	logic                     cart_wr;
	cart_pkg::cpu_data_t      cart_di;
	cart_pkg::cpu_data_t      cart_do;
	logic                     dl_active;
	logic                     dl_wr;
	cart_pkg::dl_addr_t       dl_addr;
	cart_pkg::rom_word_t      dl_data;
	logic                     dl_wait;
	cart_pkg::rom_word_addr_t rom_addr;
	cart_pkg::rom_word_t      rom_din;
	logic                     rom_we;
	logic                     rom_rd;
	logic [1:0]               rom_ds;
	cart_pkg::rom_word_t      rom_q = '0;

	// words written by downloads, keyed by word address
	cart_pkg::rom_word_t      rom_store [cart_pkg::rom_word_addr_t];
	cart_pkg::rom_word_addr_t read_addr;
	cart_pkg::cpu_data_t      ram_ref [4][4];

	gb_cart #(.CRAM_BANKS(4)) i_gb_cart (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ce_cpu   (ce_cpu),
		.cart_addr(cart_addr),
		.cart_rd  (cart_rd),
		.cart_wr  (cart_wr),
		.cart_di  (cart_di),
		.cart_do  (cart_do),
		.dl_active(dl_active),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.dl_wait  (dl_wait),
		.rom_addr (rom_addr),
		.rom_din  (rom_din),
		.rom_we   (rom_we),
		.rom_rd   (rom_rd),
		.rom_ds   (rom_ds),
		.rom_q    (rom_q)
	);

	// ------------------------------
	// clock, ce and store model
	// ------------------------------
	always #5 clk_sys = ~clk_sys;

	// one ce_cpu in eight clk_sys cycles
	always @(posedge clk_sys) begin
		#1;
		ce_phase = ce_phase + 3'd1;
		ce_cpu = (ce_phase == 3'd0);
	end

	// pattern for words never downloaded, uses every address bit
	function automatic cart_pkg::rom_word_t fill_word(input cart_pkg::rom_word_addr_t a);
		return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'hA5C3;
	endfunction

	function automatic cart_pkg::rom_word_t stored_word(input cart_pkg::rom_word_addr_t a);
		if (rom_store.exists(a))
			return rom_store[a];
		return fill_word(a);
	endfunction

	// store with one cycle of read latency
	always @(posedge clk_sys) begin
		if (rom_we)
			rom_store[rom_addr] = rom_din;
		read_addr = rom_addr;
		#1;
		rom_q = stored_word(read_addr);
	end

	// ------------------------------
	// failure reporting
	// ------------------------------
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped on first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp)
		else stop_with_failure($sformatf("** Error at %0t ns: %s is %0h, expected %0h",
			$time, name, got, exp));
	endtask

	// a store write lasts one cycle
	we_single: assert property (@(posedge clk_sys) disable iff (reset) rom_we |=> !rom_we)
		else stop_with_failure("rom_we stayed high for more than one cycle");

	// ------------------------------
	// bus tasks
	// ------------------------------

	// one clock, then 1 ns past the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// one word into the store, waits for dl_wait to drop
	task automatic download_word(input cart_pkg::dl_addr_t addr, input cart_pkg::rom_word_t data);
		int we_count;
		int cycles;
		next_cycle();
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
		@(negedge clk_sys);
		check_value("dl_wait", 32'(dl_wait), 32'd1);
		we_count = 0;
		cycles = 0;
		while (dl_wait) begin
			if (rom_we) begin
				we_count++;
				check_value("rom_addr", 32'(rom_addr), 32'(addr[24:1]));
				check_value("rom_din", 32'(rom_din), 32'(data));
				// whole word, both byte lanes
				check_value("rom_ds", 32'(rom_ds), 32'h3);
			end
			cycles++;
			assert (cycles <= 2 * CE_PERIOD + 1)
			else stop_with_failure("dl_wait stayed high longer than two ce_cpu periods");
			@(negedge clk_sys);
		end
		check_value("rom_we pulses", 32'(we_count), 32'd1);
	endtask

	// type byte and size bytes, bank registers are cleared meanwhile
	task automatic load_header(input cart_pkg::cpu_data_t mbc,
			input cart_pkg::cpu_data_t rom_size, input cart_pkg::cpu_data_t ram_size);
		next_cycle();
		dl_active = 1'b1;
		download_word(cart_pkg::HDR_MBC_ADDR, {mbc, 8'h00});
		download_word(cart_pkg::HDR_SIZE_ADDR, {ram_size, rom_size});
		next_cycle();
		dl_active = 1'b0;
	endtask

	// held until an edge with ce_cpu
	task automatic cpu_write(input cart_pkg::cpu_addr_t addr, input cart_pkg::cpu_data_t data);
		next_cycle();
		cart_rd = 1'b0;
		cart_addr = addr;
		cart_di = data;
		cart_wr = 1'b1;
		do begin
			@(posedge clk_sys);
		end while (!ce_cpu);
		#1;
		cart_wr = 1'b0;
	endtask

	// store and RAM both answer after one edge
	task automatic cpu_read(input cart_pkg::cpu_addr_t addr, output cart_pkg::cpu_data_t data,
			output cart_pkg::rom_word_addr_t word_addr);
		next_cycle();
		cart_wr = 1'b0;
		cart_addr = addr;
		cart_rd = 1'b1;
		@(negedge clk_sys);
		@(negedge clk_sys);
		data = cart_do;
		word_addr = rom_addr;
	endtask

	task automatic check_rom_read(input cart_pkg::cpu_addr_t addr,
			input cart_pkg::rom_word_addr_t exp_addr);
		cart_pkg::cpu_data_t      data;
		cart_pkg::rom_word_addr_t word_addr;
		cart_pkg::rom_word_t      word;
		cpu_read(addr, data, word_addr);
		word = stored_word(exp_addr);
		check_value("rom_addr", 32'(word_addr), 32'(exp_addr));
		check_value("rom_rd", 32'(rom_rd), 32'd1);
		// odd address strobes the upper lane only
		check_value("rom_ds", 32'(rom_ds), addr[0] ? 32'h2 : 32'h1);
		// byte lane picked by address bit 0
		check_value("cart_do", 32'(data), 32'(addr[0] ? word[15:8] : word[7:0]));
	endtask

	task automatic check_ram_read(input cart_pkg::cpu_addr_t addr, input cart_pkg::cpu_data_t exp);
		cart_pkg::cpu_data_t      data;
		cart_pkg::rom_word_addr_t word_addr;
		cpu_read(addr, data, word_addr);
		check_value("rom_rd", 32'(rom_rd), 32'd0);
		check_value("cart_do", 32'(data), 32'(exp));
	endtask

	// ------------------------------
	// reference rules
	// ------------------------------

	// switchable window, 16 KB bank over the 8 KB half
	function automatic cart_pkg::rom_word_addr_t window_addr(input cart_pkg::rom_bank_t bank,
			input cart_pkg::cpu_addr_t addr);
		return {3'b000, 1'b0, bank, addr[13], addr[12:1]};
	endfunction

	// zero becomes one, mode 0 puts the RAM bank on top, then the mask
	function automatic cart_pkg::rom_bank_t mbc1_bank(input cart_pkg::cpu_data_t written,
			input cart_pkg::ram_bank_t ram, input logic mode, input cart_pkg::rom_bank_t mask);
		cart_pkg::rom_bank_t bank;
		bank = (written[4:0] == 5'd0) ? 7'd1 : written[6:0];
		if (!mode)
			bank[6:5] = ram;
		return bank & mask;
	endfunction

	// MBC1 with a 1 MB ROM, mask 3F
	task automatic mbc1_bank_check(input cart_pkg::cpu_data_t written,
			input cart_pkg::ram_bank_t ram, input logic mode);
		cart_pkg::cpu_addr_t addr;
		addr = {2'b01, 14'($urandom())};
		cpu_write(16'h2000, written);
		check_rom_read(addr, window_addr(mbc1_bank(written, ram, mode, 7'h3F), addr));
	endtask

	function automatic cart_pkg::cpu_addr_t ram_slot(input int k);
		return 16'(32'hA011 + k * 32'h0731);
	endfunction

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		cart_pkg::cpu_addr_t addr;
		cart_pkg::cpu_data_t data;
		reset = 1'b1;
		cart_addr = '0;
		cart_rd = 1'b0;
		cart_wr = 1'b0;
		cart_di = '0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		void'($urandom(32'h7009_5d30));
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// idle after reset, then a single download write
		@(negedge clk_sys);
		check_value("cart_do", 32'(cart_do), 32'h00);
		check_value("rom_we", 32'(rom_we), 32'd0);
		next_cycle();
		dl_active = 1'b1;
		download_word(25'h000010, 16'($urandom()));
		next_cycle();
		dl_active = 1'b0;

		// MBC1, ROM size 5, 32 KB RAM
		load_header(8'h01, 8'h05, 8'h03);
		cpu_write(16'h4000, 8'h00);
		mbc1_bank_check(8'h00, 2'd0, 1'b0);
		mbc1_bank_check(8'h05, 2'd0, 1'b0);
		mbc1_bank_check(8'h45, 2'd0, 1'b0);
		cpu_write(16'h4000, 8'h01);
		mbc1_bank_check(8'h03, 2'd1, 1'b0);
		cpu_write(16'h6000, 8'h01);
		mbc1_bank_check(8'h45, 2'd1, 1'b1);

		// MBC5 keeps bank 0
		load_header(8'h19, 8'h06, 8'h00);
		cpu_write(16'h2000, 8'h00);
		check_rom_read(16'h4567, window_addr(7'h00, 16'h4567));
		cpu_write(16'h2000, 8'h42);
		check_rom_read(16'h7ABC, window_addr(7'h42, 16'h7ABC));
		// no mapper, 32 KB linear
		load_header(8'h00, 8'h00, 8'h00);
		for (int i = 0; i < 4; i++) begin
			addr = {1'b0, 2'(i), 13'($urandom())};
			check_rom_read(addr, {10'd0, addr[14:1]});
		end

		// banked RAM behind MBC3
		load_header(8'h13, 8'h05, 8'h03);
		cpu_write(16'h0000, 8'h0A);
		for (int b = 0; b < 4; b++) begin
			cpu_write(16'h4000, 8'(b));
			for (int k = 0; k < 4; k++) begin
				ram_ref[b][k] = 8'($urandom());
				cpu_write(ram_slot(k), ram_ref[b][k]);
			end
		end
		for (int b = 0; b < 4; b++) begin
			cpu_write(16'h4000, 8'(b));
			for (int k = 0; k < 4; k++)
				check_ram_read(ram_slot(k), ram_ref[b][k]);
		end
		// closed RAM reads high
		cpu_write(16'h0000, 8'h00);
		check_ram_read(ram_slot(1), 8'hFF);

		// MBC2 nibble RAM and ROM byte lanes
		load_header(8'h05, 8'h03, 8'h00);
		cpu_write(16'h0000, 8'h0A);
		data = 8'($urandom());
		cpu_write(16'hA010, data);
		check_ram_read(16'hA010, {4'hF, data[3:0]});
		cpu_write(16'h2000, 8'h02);
		check_rom_read(16'h4001, window_addr(7'h02, 16'h4001));
		check_rom_read(16'h4000, window_addr(7'h02, 16'h4000));

		next_cycle();
		$display("Simulation PASSED");
		$finish;
	end

	// watchdog, twice the worst case length of the run
	initial begin
		#(RUN_CYCLES * 10 * 2);
		stop_with_failure("watchdog timeout, the tests did not finish in time");
	end

endmodule
